//--- alu_exe.sv
/* Single ALU, issues in order from the head of its FIFO.
   An entry waits until both source copies are written back, no forwarding.
   Result is registered, so writeback comes one cycle after issue. */
`timescale 1ns/100ps
`default_nettype none

module alu_exe import be_pkg::*; #(
	parameter int DW = 64
) (
	input  logic          CLK,
	input  logic          i_arst_n,
	input  logic          i_flush,
	input  alu_issue_t    i_iq_head,
	input  logic          i_iq_empty,
	input  wb_vec_t       i_wb_done,
	input  logic [DW-1:0] i_rs1_data,
	input  logic [DW-1:0] i_rs2_data,
	output logic          o_iq_pop,
	output phy_tag_t      o_rs1_tag,
	output phy_tag_t      o_rs2_tag,
	output wb_t           o_wb,
	output logic [DW-1:0] o_wb_data
);

	logic          issue;
	logic [DW-1:0] imm_ext;
	logic [DW-1:0] result;
	logic          slt;
	logic          wb_valid_q;
	phy_tag_t      wb_tag_q;
	logic [DW-1:0] wb_data_q;

	assign o_rs1_tag = i_iq_head.rs1;
	assign o_rs2_tag = i_iq_head.rs2;

	// both operands ready, nothing issues in the flush cycle
	assign issue = !i_iq_empty && !i_flush &&
		i_wb_done[tag_idx(i_iq_head.rs1)] && i_wb_done[tag_idx(i_iq_head.rs2)];
	assign o_iq_pop = issue;

	assign imm_ext = {{(DW-12){i_iq_head.imm[11]}}, i_iq_head.imm};
	assign slt     = $signed(i_rs1_data) < $signed(i_rs2_data);

	always_comb begin
		case (i_iq_head.op)
			ALU_ADD:  result = i_rs1_data + i_rs2_data;
			ALU_SUB:  result = i_rs1_data - i_rs2_data;
			ALU_AND:  result = i_rs1_data & i_rs2_data;
			ALU_OR:   result = i_rs1_data | i_rs2_data;
			ALU_XOR:  result = i_rs1_data ^ i_rs2_data;
			ALU_ADDI: result = i_rs1_data + imm_ext;
			ALU_SLT:  result = {{(DW-1){1'b0}}, slt};
			default:  result = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n)
			wb_valid_q <= 1'b0;
		else if (i_flush)
			wb_valid_q <= 1'b0;
		else
			wb_valid_q <= issue;
	end

	// payload only
	always_ff @(posedge CLK) begin
		if (issue) begin
			wb_tag_q  <= i_iq_head.rd;
			wb_data_q <= result;
		end
	end

	assign o_wb      = '{valid: wb_valid_q, tag: wb_tag_q};
	assign o_wb_data = wb_data_q;

endmodule

`default_nettype wire

//--- back_ctrl.sv
/* Rename and dispatch, in-order commit and branch resolution.
   At most one micro-op is dispatched and one committed per cycle.
   A mispredict resolved at the head gives a one-cycle o_flush in the
   following cycle, with no dispatch in either cycle. */
`timescale 1ns/100ps
`default_nettype none

module back_ctrl import be_pkg::*; (
	input  logic       CLK,
	input  logic       i_arst_n,
	input  uop_t       i_uop,
	input  logic       i_uop_empty,
	input  logic       i_br_resolve,
	input  logic       i_br_mispredict,
	input  rob_entry_t i_rob_head,
	input  logic       i_rob_empty,
	input  logic       i_rob_full,
	input  logic       i_iq_full,
	input  free_vec_t  i_free_copy,
	input  phy_tag_t   i_src1_tag,
	input  phy_tag_t   i_src2_tag,
	input  wb_vec_t    i_wb_done,
	output logic       o_uop_pop,
	output wb_t        o_rename,
	output logic       o_iq_push,
	output alu_issue_t o_iq_data,
	output logic       o_rob_push,
	output rob_entry_t o_rob_data,
	output logic       o_rob_pop,
	output wb_t        o_commit_tag,
	output commit_t    o_commit,
	output logic       o_flush
);

	ctrl_state_e state_q;
	ctrl_state_e state_d;

	logic       is_alu;
	logic       needs_rd;
	free_copy_t rd_free;
	phy_tag_t   rd_tag;
	phy_tag_t   rs2_tag;
	logic       accept;

	logic       head_alu_done;
	logic       head_br_done;
	logic       do_commit;
	logic       flush_req;

	// commit side

	// an ALU entry without rd never executes and retires at once
	assign head_alu_done = (i_rob_head.kind == UOP_ALU) &&
		(!i_rob_head.has_rd || i_wb_done[tag_idx(i_rob_head.rd)]);
	assign head_br_done  = (i_rob_head.kind == UOP_BRANCH) && i_br_resolve;

	assign do_commit = (state_q == ST_RUN) && !i_rob_empty && (head_alu_done || head_br_done);
	assign flush_req = do_commit && (i_rob_head.kind == UOP_BRANCH) && i_br_mispredict;

	assign o_rob_pop    = do_commit;
	assign o_commit_tag = '{valid: do_commit && i_rob_head.has_rd, tag: i_rob_head.rd};
	assign o_commit     = '{
		valid:     do_commit,
		is_branch: i_rob_head.kind == UOP_BRANCH,
		has_rd:    i_rob_head.has_rd,
		rd:        i_rob_head.rd.arch
	};

	// dispatch side

	// writes to x0 get no destination and never enter the ALU
	assign is_alu   = (i_uop.kind == UOP_ALU);
	assign needs_rd = is_alu && (i_uop.rd != '0);
	assign rd_free  = i_free_copy[i_uop.rd];
	assign rd_tag   = needs_rd ? '{arch: i_uop.rd, copy: rd_free.copy} : '0;

	// ADDI has no rs2, point it at x0 which is always written back
	assign rs2_tag = (i_uop.op == ALU_ADDI) ? '0 : i_src2_tag;

	assign accept = (state_q == ST_RUN) && !flush_req && !i_uop_empty && !i_rob_full &&
		(!is_alu || !i_iq_full) && (!needs_rd || rd_free.avail);

	assign o_uop_pop  = accept;
	assign o_rename   = '{valid: accept && needs_rd, tag: rd_tag};
	assign o_rob_push = accept;
	assign o_rob_data = '{kind: i_uop.kind, has_rd: needs_rd, rd: rd_tag};
	assign o_iq_push  = accept && needs_rd;
	assign o_iq_data  = '{
		op:  i_uop.op,
		rd:  rd_tag,
		rs1: i_src1_tag,
		rs2: rs2_tag,
		imm: i_uop.imm
	};

	// flush sequencing
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_RUN: begin
				if (flush_req)
					state_d = ST_FLUSH;
			end
			ST_FLUSH: state_d = ST_RUN;
			default:  state_d = ST_RUN;
		endcase
	end

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n)
			state_q <= ST_RUN;
		else
			state_q <= state_d;
	end

	assign o_flush = (state_q == ST_FLUSH);

endmodule

`default_nettype wire

//--- back_end.sv
/* Back end top: one ALU, a reorder FIFO of 2**ROB_AW entries and an
   issue FIFO of 2**IQ_AW entries. i_uop must stay stable while
   i_uop_empty is low and o_uop_pop has not been seen. */
`timescale 1ns/100ps
`default_nettype none

module back_end import be_pkg::*; #(
	parameter int DW     = 64,
	parameter int ROB_AW = 3,
	parameter int IQ_AW  = 2
) (
	input  logic          CLK,
	input  logic          i_arst_n,
	input  uop_t          i_uop,
	input  logic          i_uop_empty,
	input  logic          i_br_resolve,
	input  logic          i_br_mispredict,
	output logic          o_uop_pop,
	output commit_t       o_commit,
	output logic [DW-1:0] o_commit_data,
	output logic          o_flush
);

	wb_t           rename;
	wb_t           commit_tag;
	logic          iq_push;
	logic          iq_pop;
	logic          iq_full;
	logic          iq_empty;
	alu_issue_t    iq_data;
	alu_issue_t    iq_head;
	logic          rob_push;
	logic          rob_pop;
	logic          rob_full;
	logic          rob_empty;
	rob_entry_t    rob_data;
	rob_entry_t    rob_head;
	free_vec_t     free_copy;
	phy_tag_t      src1_tag;
	phy_tag_t      src2_tag;
	phy_tag_t      rs1_tag;
	phy_tag_t      rs2_tag;
	wb_vec_t       wb_done;
	wb_t           wb;
	logic [DW-1:0] wb_data;
	logic [DW-1:0] rs1_data;
	logic [DW-1:0] rs2_data;

	back_ctrl u_back_ctrl (
		.CLK             (CLK),
		.i_arst_n        (i_arst_n),
		.i_uop           (i_uop),
		.i_uop_empty     (i_uop_empty),
		.i_br_resolve    (i_br_resolve),
		.i_br_mispredict (i_br_mispredict),
		.i_rob_head      (rob_head),
		.i_rob_empty     (rob_empty),
		.i_rob_full      (rob_full),
		.i_iq_full       (iq_full),
		.i_free_copy     (free_copy),
		.i_src1_tag      (src1_tag),
		.i_src2_tag      (src2_tag),
		.i_wb_done       (wb_done),
		.o_uop_pop       (o_uop_pop),
		.o_rename        (rename),
		.o_iq_push       (iq_push),
		.o_iq_data       (iq_data),
		.o_rob_push      (rob_push),
		.o_rob_data      (rob_data),
		.o_rob_pop       (rob_pop),
		.o_commit_tag    (commit_tag),
		.o_commit        (o_commit),
		.o_flush         (o_flush)
	);

	phy_regfile #(.DW(DW)) u_phy_regfile (
		.CLK          (CLK),
		.i_arst_n     (i_arst_n),
		.i_rename     (rename),
		.i_commit_tag (commit_tag),
		.i_flush      (o_flush),
		.i_wb         (wb),
		.i_wb_data    (wb_data),
		.i_src1_arch  (i_uop.rs1),
		.i_src2_arch  (i_uop.rs2),
		.i_rd_tag_a   (rs1_tag),
		.i_rd_tag_b   (rs2_tag),
		.i_rd_tag_c   (commit_tag.tag),
		.o_src1_tag   (src1_tag),
		.o_src2_tag   (src2_tag),
		.o_free_copy  (free_copy),
		.o_wb_done    (wb_done),
		.o_rd_data_a  (rs1_data),
		.o_rd_data_b  (rs2_data),
		.o_rd_data_c  (o_commit_data)
	);

	alu_exe #(.DW(DW)) u_alu_exe (
		.CLK        (CLK),
		.i_arst_n   (i_arst_n),
		.i_flush    (o_flush),
		.i_iq_head  (iq_head),
		.i_iq_empty (iq_empty),
		.i_wb_done  (wb_done),
		.i_rs1_data (rs1_data),
		.i_rs2_data (rs2_data),
		.o_iq_pop   (iq_pop),
		.o_rs1_tag  (rs1_tag),
		.o_rs2_tag  (rs2_tag),
		.o_wb       (wb),
		.o_wb_data  (wb_data)
	);

	gen_fifo #(.DW($bits(alu_issue_t)), .AW(IQ_AW)) iq_fifo (
		.CLK      (CLK),
		.i_arst_n (i_arst_n),
		.i_flush  (o_flush),
		.i_push   (iq_push),
		.i_data   (iq_data),
		.i_pop    (iq_pop),
		.o_data   (iq_head),
		.o_full   (iq_full),
		.o_empty  (iq_empty)
	);

	gen_fifo #(.DW($bits(rob_entry_t)), .AW(ROB_AW)) rob_fifo (
		.CLK      (CLK),
		.i_arst_n (i_arst_n),
		.i_flush  (o_flush),
		.i_push   (rob_push),
		.i_data   (rob_data),
		.i_pop    (rob_pop),
		.o_data   (rob_head),
		.o_full   (rob_full),
		.o_empty  (rob_empty)
	);

endmodule

`default_nettype wire

//--- back_end_chk.sv
/* Protocol checks on back_ctrl, bound into every instance of it.
   All checks are idle while i_arst_n is low. */
`timescale 1ns/100ps
`default_nettype none

module back_end_chk import be_pkg::*; (
	input  logic    CLK,
	input  logic    i_arst_n,
	input  logic    i_flush,
	input  logic    i_uop_pop,
	input  commit_t i_commit,
	input  logic    i_rob_empty,
	input  logic    i_rob_full,
	input  logic    i_rob_push,
	input  logic    i_iq_full,
	input  logic    i_iq_push
);

	// flush lasts exactly one cycle
	flush_pulse: assert property (@(posedge CLK) disable iff (!i_arst_n)
		i_flush |=> !i_flush)
		else $error("o_flush high for more than one cycle");

	no_pop_in_flush: assert property (@(posedge CLK) disable iff (!i_arst_n)
		i_flush |-> !i_uop_pop)
		else $error("micro-op accepted during the flush cycle");

	commit_needs_entry: assert property (@(posedge CLK) disable iff (!i_arst_n)
		i_commit.valid |-> !i_rob_empty)
		else $error("commit reported with the reorder FIFO empty");

	// both FIFOs drop a push while full, so a push there loses a micro-op
	rob_push_room: assert property (@(posedge CLK) disable iff (!i_arst_n)
		i_rob_push |-> !i_rob_full)
		else $error("push into a full reorder FIFO");

	iq_push_room: assert property (@(posedge CLK) disable iff (!i_arst_n)
		i_iq_push |-> !i_iq_full)
		else $error("push into a full issue FIFO");

endmodule

bind back_ctrl back_end_chk u_chk (
	.CLK         (CLK),
	.i_arst_n    (i_arst_n),
	.i_flush     (o_flush),
	.i_uop_pop   (o_uop_pop),
	.i_commit    (o_commit),
	.i_rob_empty (i_rob_empty),
	.i_rob_full  (i_rob_full),
	.i_rob_push  (o_rob_push),
	.i_iq_full   (i_iq_full),
	.i_iq_push   (o_iq_push)
);

`default_nettype wire

//--- be_pkg.sv
/* Types shared by the integer back end and its testbench.
   A physical tag indexes the written-back vector as {arch, copy}.
   The width of copy_idx_t must cover RN_COPIES. */
`default_nettype none

package be_pkg;

	localparam int NREGS     = 32;
	localparam int RN_COPIES = 4;

	typedef logic [4:0]                   arch_idx_t;
	typedef logic [1:0]                   copy_idx_t;
	typedef logic [11:0]                  imm_t;
	typedef logic [RN_COPIES-1:0]         copy_vec_t;
	typedef logic [NREGS*RN_COPIES-1:0]   wb_vec_t;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_ADDI, ALU_SLT
	} alu_op_e;

	typedef enum logic {UOP_ALU, UOP_BRANCH} uop_kind_e;

	typedef enum logic {ST_RUN, ST_FLUSH} ctrl_state_e;

	typedef struct packed {
		uop_kind_e kind;
		alu_op_e   op;
		arch_idx_t rd;
		arch_idx_t rs1;
		arch_idx_t rs2;
		imm_t      imm;
	} uop_t;

	typedef struct packed {
		arch_idx_t arch;
		copy_idx_t copy;
	} phy_tag_t;

	typedef struct packed {
		alu_op_e  op;
		phy_tag_t rd;
		phy_tag_t rs1;
		phy_tag_t rs2;
		imm_t     imm;
	} alu_issue_t;

	typedef struct packed {
		uop_kind_e kind;
		logic      has_rd;
		phy_tag_t  rd;
	} rob_entry_t;

	typedef struct packed {
		logic      valid;
		logic      is_branch;
		logic      has_rd;
		arch_idx_t rd;
	} commit_t;

	typedef struct packed {
		logic     valid;
		phy_tag_t tag;
	} wb_t;

	// lowest free copy of one register
	typedef struct packed {
		logic      avail;
		copy_idx_t copy;
	} free_copy_t;

	typedef free_copy_t [NREGS-1:0] free_vec_t;

	function automatic int unsigned tag_idx(phy_tag_t t);
		return {t.arch, t.copy};
	endfunction

endpackage

`default_nettype wire

//--- gen_fifo.sv
/* Synchronous FIFO, depth 2**AW, head read combinationally.
   Push while full and pop while empty are ignored.
   i_flush empties the FIFO in one cycle. */
`timescale 1ns/100ps
`default_nettype none

module gen_fifo #(
	parameter int DW = 8,
	parameter int AW = 4
) (
	input  logic          CLK,
	input  logic          i_arst_n,
	input  logic          i_flush,
	input  logic          i_push,
	input  logic [DW-1:0] i_data,
	input  logic          i_pop,
	output logic [DW-1:0] o_data,
	output logic          o_full,
	output logic          o_empty
);

	logic [DW-1:0] mem [2**AW];
	// one extra bit tells full from empty
	logic [AW:0]   wr_ptr;
	logic [AW:0]   rd_ptr;
	logic          do_push;
	logic          do_pop;

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign o_data  = mem[rd_ptr[AW-1:0]];

	assign do_push = i_push && !o_full;
	assign do_pop  = i_pop && !o_empty;

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (i_flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr[AW-1:0]] <= i_data;
	end

endmodule

`default_nettype wire

//--- phy_regfile.sv
/* Physical register copies with rename bookkeeping, RN_COPIES per register.
   x0 is never renamed and writes to it are dropped.
   Flush keeps only the committed copies; writebacks in that cycle are lost. */
`timescale 1ns/100ps
`default_nettype none

module phy_regfile import be_pkg::*; #(
	parameter int DW = 64
) (
	input  logic          CLK,
	input  logic          i_arst_n,
	input  wb_t           i_rename,
	input  wb_t           i_commit_tag,
	input  logic          i_flush,
	input  wb_t           i_wb,
	input  logic [DW-1:0] i_wb_data,
	input  arch_idx_t     i_src1_arch,
	input  arch_idx_t     i_src2_arch,
	input  phy_tag_t      i_rd_tag_a,
	input  phy_tag_t      i_rd_tag_b,
	input  phy_tag_t      i_rd_tag_c,
	output phy_tag_t      o_src1_tag,
	output phy_tag_t      o_src2_tag,
	output free_vec_t     o_free_copy,
	output wb_vec_t       o_wb_done,
	output logic [DW-1:0] o_rd_data_a,
	output logic [DW-1:0] o_rd_data_b,
	output logic [DW-1:0] o_rd_data_c
);

	logic [DW-1:0] copy_q [NREGS][RN_COPIES];
	copy_idx_t     act_q [NREGS];
	copy_idx_t     cmt_q [NREGS];
	logic [NREGS-1:0][RN_COPIES-1:0] in_use_q;
	logic [NREGS-1:0][RN_COPIES-1:0] wb_q;
	logic          wb_ok;

	// stale results to dropped copies are discarded
	assign wb_ok = i_wb.valid && !i_flush && (i_wb.tag.arch != '0) &&
		in_use_q[i_wb.tag.arch][i_wb.tag.copy];

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int r = 0; r < NREGS; r++) begin
				act_q[r]    <= '0;
				cmt_q[r]    <= '0;
				in_use_q[r] <= copy_vec_t'(1);
				wb_q[r]     <= copy_vec_t'(1);
			end
		end else if (i_flush) begin
			for (int r = 0; r < NREGS; r++) begin
				act_q[r]    <= cmt_q[r];
				in_use_q[r] <= copy_vec_t'(1) << cmt_q[r];
			end
		end else begin
			if (wb_ok)
				wb_q[i_wb.tag.arch][i_wb.tag.copy] <= 1'b1;
			// release the previous architectural copy
			if (i_commit_tag.valid) begin
				in_use_q[i_commit_tag.tag.arch][cmt_q[i_commit_tag.tag.arch]] <= 1'b0;
				cmt_q[i_commit_tag.tag.arch] <= i_commit_tag.tag.copy;
			end
			if (i_rename.valid) begin
				in_use_q[i_rename.tag.arch][i_rename.tag.copy] <= 1'b1;
				wb_q[i_rename.tag.arch][i_rename.tag.copy]     <= 1'b0;
				act_q[i_rename.tag.arch] <= i_rename.tag.copy;
			end
		end
	end

	always_ff @(posedge CLK or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int r = 0; r < NREGS; r++)
				for (int c = 0; c < RN_COPIES; c++)
					copy_q[r][c] <= '0;
		end else if (wb_ok) begin
			copy_q[i_wb.tag.arch][i_wb.tag.copy] <= i_wb_data;
		end
	end

	// lowest copy not in use, searched from the top so the lowest wins
	always_comb begin
		for (int r = 0; r < NREGS; r++) begin
			o_free_copy[r] = '0;
			for (int c = RN_COPIES - 1; c >= 0; c--) begin
				if (!in_use_q[r][c]) begin
					o_free_copy[r].avail = 1'b1;
					o_free_copy[r].copy  = copy_idx_t'(c);
				end
			end
		end
	end

	assign o_src1_tag  = '{arch: i_src1_arch, copy: act_q[i_src1_arch]};
	assign o_src2_tag  = '{arch: i_src2_arch, copy: act_q[i_src2_arch]};
	assign o_wb_done   = wb_q;
	assign o_rd_data_a = copy_q[i_rd_tag_a.arch][i_rd_tag_a.copy];
	assign o_rd_data_b = copy_q[i_rd_tag_b.arch][i_rd_tag_b.copy];
	assign o_rd_data_c = copy_q[i_rd_tag_c.arch][i_rd_tag_c.copy];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the back end testbench with Verilator
# exits non-zero when the build fails or the log reports failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module tb_back_end -Mdir obj_dir -o tb_back_end
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_back_end > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
exit 0

//--- tb.f
be_pkg.sv
gen_fifo.sv
phy_regfile.sv
alu_exe.sv
back_ctrl.sv
back_end.sv
back_end_chk.sv
tb_back_end.sv

//--- tb_back_end.sv
/* Directed testbench for back_end with an architectural reference model.
   The instruction FIFO is modelled by a queue; at most one branch is in flight.
   Outputs are sampled SETTLE ns after the falling edge, before the rising edge. */
`timescale 1ns/100ps
`default_nettype none

module tb_back_end import be_pkg::*; ();

	localparam int DW              = 32;
	localparam int ROB_AW          = 3;
	localparam int IQ_AW           = 2;
	localparam int ROB_DEPTH       = 1 << ROB_AW;
	localparam int CLK_PERIOD      = 10;
	localparam int SETTLE          = 4;
	// micro-ops and branch hold cycles over all tests
	localparam int N_UOPS          = 53;
	localparam int HOLD_TOTAL      = 58;
	localparam int WATCHDOG_CYCLES = N_UOPS * 20 + HOLD_TOTAL + 10;
	localparam logic [31:0] RND_SEED = 32'he564_8371;

	logic          clk;
	logic          arst_n;
	uop_t          uop;
	logic          uop_empty;
	logic          br_resolve;
	logic          br_mispredict;
	logic          uop_pop;
	commit_t       commit;
	logic [DW-1:0] commit_data;
	logic          flush;

	uop_t          prog [$];
	uop_t          inflight [$];
	logic [DW-1:0] arch_q [NREGS];
	string         test_name;
	int            n_checks;
	int            n_errors;
	int            stream_cyc;
	int            rel_cycle;
	logic          mis_sel;
	logic          flush_due;
	int            pops;
	int            pops_at_rel;
	int            flushed;

	back_end #(.DW(DW), .ROB_AW(ROB_AW), .IQ_AW(IQ_AW)) dut (
		.CLK             (clk),
		.i_arst_n        (arst_n),
		.i_uop           (uop),
		.i_uop_empty     (uop_empty),
		.i_br_resolve    (br_resolve),
		.i_br_mispredict (br_mispredict),
		.o_uop_pop       (uop_pop),
		.o_commit        (commit),
		.o_commit_data   (commit_data),
		.o_flush         (flush)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the back end stopped progressing",
			WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	function automatic uop_t alu_uop(alu_op_e op, int rd, int rs1, int rs2, int imm);
		uop_t u;
		u.kind = UOP_ALU;
		u.op   = op;
		u.rd   = arch_idx_t'(rd);
		u.rs1  = arch_idx_t'(rs1);
		u.rs2  = arch_idx_t'(rs2);
		u.imm  = imm_t'(imm);
		return u;
	endfunction

	function automatic uop_t branch_uop();
		uop_t u;
		u      = '0;
		u.kind = UOP_BRANCH;
		return u;
	endfunction

	function automatic int rand_imm();
		return int'($urandom % 4096) - 2048;
	endfunction

	// architectural result of one ALU micro-op
	function automatic logic [DW-1:0] alu_model(alu_op_e op, logic [DW-1:0] a,
		logic [DW-1:0] b, imm_t imm);
		logic signed [DW-1:0] simm;
		simm = $signed(imm);
		case (op)
			ALU_ADD:  return a + b;
			ALU_SUB:  return a - b;
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_ADDI: return a + simm;
			ALU_SLT:  return ($signed(a) < $signed(b)) ? DW'(1) : '0;
			default:  return '0;
		endcase
	endfunction

	function automatic logic branch_in_flight();
		foreach (inflight[i])
			if (inflight[i].kind == UOP_BRANCH)
				return 1'b1;
		return 1'b0;
	endfunction

	task automatic check_val(string what, logic [DW-1:0] exp, logic [DW-1:0] act);
		n_checks++;
		assert (act === exp) else begin
			n_errors++;
			$display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
		end
	endtask

	task automatic note_error(string msg);
		n_errors++;
		$display("ERROR %s: %s", test_name, msg);
	endtask

	task automatic drive_inputs();
		uop_empty     = (prog.size() == 0);
		uop           = (prog.size() != 0) ? prog[0] : '0;
		br_resolve    = branch_in_flight() && (stream_cyc >= rel_cycle);
		br_mispredict = br_resolve && mis_sel;
		if (stream_cyc == rel_cycle)
			pops_at_rel = pops;
	endtask

	task automatic check_commit();
		uop_t          exp_u;
		logic          exp_br;
		logic          exp_rd;
		logic [DW-1:0] exp_val;
		assert (inflight.size() != 0) else note_error("commit with no micro-op in flight");
		if (inflight.size() != 0) begin
			exp_u  = inflight.pop_front();
			exp_br = (exp_u.kind == UOP_BRANCH);
			exp_rd = !exp_br && (exp_u.rd != '0);
			check_val("is_branch", DW'(exp_br), DW'(commit.is_branch));
			check_val("has_rd", DW'(exp_rd), DW'(commit.has_rd));
			if (exp_rd) begin
				exp_val = alu_model(exp_u.op, arch_q[exp_u.rs1], arch_q[exp_u.rs2], exp_u.imm);
				check_val("rd", DW'(exp_u.rd), DW'(commit.rd));
				check_val($sformatf("x%0d value", exp_u.rd), exp_val, commit_data);
				arch_q[exp_u.rd] = exp_val;
			end
			// wrong path is dropped, front end redirects
			if (exp_br && mis_sel) begin
				flushed += inflight.size();
				inflight.delete();
				prog.delete();
				flush_due = 1'b1;
			end
		end
	endtask

	task automatic observe();
		check_val("o_flush", DW'(flush_due), DW'(flush));
		flush_due = 1'b0;
		if (uop_pop) begin
			assert (prog.size() != 0) else note_error("o_uop_pop with the instruction FIFO empty");
			if (prog.size() != 0) begin
				inflight.push_back(prog.pop_front());
				pops++;
			end
		end
		if (commit.valid)
			check_commit();
	endtask

	task automatic step();
		@(negedge clk);
		drive_inputs();
		#(SETTLE);
		observe();
		stream_cyc++;
	endtask

	// runs prog to completion, the branch is resolved from cycle hold on
	task automatic run_stream(int hold, logic mispredict);
		stream_cyc  = 0;
		rel_cycle   = hold;
		mis_sel     = mispredict;
		pops        = 0;
		pops_at_rel = 0;
		flushed     = 0;
		while (prog.size() != 0 || inflight.size() != 0 || flush_due)
			step();
		mis_sel = 1'b0;
	endtask

	task automatic reset_state();
		test_name = "reset_state";
		// idle, no pop, commit or flush may appear
		repeat (4) step();
		for (int r = 1; r <= 4; r++)
			prog.push_back(alu_uop(ALU_ADDI, r, 0, 0, rand_imm()));
		run_stream(0, 1'b0);
	endtask

	task automatic ops_and_deps();
		test_name = "ops_and_deps";
		prog.push_back(alu_uop(ALU_ADDI, 1, 0, 0, rand_imm()));
		prog.push_back(alu_uop(ALU_ADDI, 2, 0, 0, rand_imm()));
		prog.push_back(alu_uop(ALU_ADD, 3, 1, 2, 0));
		prog.push_back(alu_uop(ALU_SUB, 4, 3, 1, 0));
		prog.push_back(alu_uop(ALU_AND, 5, 4, 2, 0));
		prog.push_back(alu_uop(ALU_OR, 6, 5, 3, 0));
		prog.push_back(alu_uop(ALU_XOR, 7, 6, 4, 0));
		prog.push_back(alu_uop(ALU_SLT, 8, 7, 1, 0));
		prog.push_back(alu_uop(ALU_SLT, 9, 1, 7, 0));
		prog.push_back(alu_uop(ALU_ADDI, 10, 9, 0, -5));
		// x0 destination retires without a result
		prog.push_back(alu_uop(ALU_ADD, 0, 1, 2, 0));
		prog.push_back(alu_uop(ALU_SUB, 11, 0, 10, 0));
		run_stream(0, 1'b0);
	endtask

	task automatic rename_pressure();
		test_name = "rename_pressure";
		prog.push_back(alu_uop(ALU_ADDI, 12, 0, 0, rand_imm()));
		// seven more writes, only three spare copies
		for (int k = 1; k <= 7; k++)
			prog.push_back(alu_uop(ALU_ADDI, 12, 12, 0, k * 3));
		prog.push_back(alu_uop(ALU_ADD, 13, 12, 12, 0));
		run_stream(0, 1'b0);
	endtask

	task automatic branch_resolved();
		test_name = "branch_resolved";
		prog.push_back(alu_uop(ALU_ADDI, 14, 0, 0, rand_imm()));
		prog.push_back(branch_uop());
		prog.push_back(alu_uop(ALU_ADDI, 15, 14, 0, 9));
		prog.push_back(alu_uop(ALU_ADD, 16, 15, 14, 0));
		run_stream(6, 1'b0);
	endtask

	task automatic branch_mispredict();
		test_name = "branch_mispredict";
		prog.push_back(alu_uop(ALU_ADDI, 1, 0, 0, rand_imm()));
		prog.push_back(alu_uop(ALU_ADDI, 2, 0, 0, rand_imm()));
		prog.push_back(alu_uop(ALU_ADDI, 3, 0, 0, rand_imm()));
		prog.push_back(branch_uop());
		// wrong path overwrites the sources read later
		prog.push_back(alu_uop(ALU_ADDI, 1, 1, 0, 100));
		prog.push_back(alu_uop(ALU_ADD, 2, 1, 1, 0));
		prog.push_back(alu_uop(ALU_ADDI, 3, 0, 0, 55));
		prog.push_back(alu_uop(ALU_XOR, 17, 1, 2, 0));
		run_stream(12, 1'b1);
		assert (flushed != 0) else note_error("no younger micro-op was in flight at the mispredict");
		prog.push_back(alu_uop(ALU_ADD, 18, 1, 2, 0));
		prog.push_back(alu_uop(ALU_OR, 19, 3, 0, 0));
		prog.push_back(alu_uop(ALU_ADDI, 20, 3, 0, 0));
		run_stream(0, 1'b0);
	endtask

	task automatic rob_backpressure();
		test_name = "rob_backpressure";
		prog.push_back(branch_uop());
		for (int k = 0; k < 12; k++)
			prog.push_back(alu_uop(ALU_ADDI, 20 + k, 0, 0, rand_imm()));
		run_stream(40, 1'b0);
		check_val("pops while the branch was held", DW'(ROB_DEPTH), DW'(pops_at_rel));
	endtask

	initial begin
		void'($urandom(RND_SEED));
		arst_n        = 1'b0;
		uop           = '0;
		uop_empty     = 1'b1;
		br_resolve    = 1'b0;
		br_mispredict = 1'b0;
		n_checks      = 0;
		n_errors      = 0;
		stream_cyc    = 0;
		rel_cycle     = 0;
		mis_sel       = 1'b0;
		flush_due     = 1'b0;
		pops          = 0;
		pops_at_rel   = 0;
		foreach (arch_q[r])
			arch_q[r] = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		reset_state();
		ops_and_deps();
		rename_pressure();
		branch_resolved();
		branch_mispredict();
		rob_backpressure();

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
